/* bench/mulInput.txt */
# Columns: op (1 MUL, 2 MULH, 3 MULHU, any other code is not a multiply),
# operand a, operand b, flush bit, expected resultMul. All values in hex.
# MUL, low word of the signed product
1 00000003 00000005 0 0000000f
1 ffffffff 00000005 0 fffffffb
1 fffffffd fffffff9 0 00000015
1 fffffff0 00000010 0 ffffff00
1 7fffffff 00000002 0 fffffffe
1 80000000 00000001 0 80000000
1 80000000 ffffffff 0 80000000
1 80000000 80000000 0 00000000
1 12345678 00000010 0 23456780
1 0000ffff 0000ffff 0 fffe0001
# MULH, high word of the signed product
2 80000000 80000000 0 40000000
2 ffffffff 00000005 0 ffffffff
2 80000000 00000001 0 ffffffff
2 7fffffff 7fffffff 0 3fffffff
2 80000000 7fffffff 0 c0000000
2 00000003 00000005 0 00000000
2 fffffffd fffffff9 0 00000000
2 00010000 00010000 0 00000001
# MULHU, high word of the unsigned product
3 ffffffff ffffffff 0 fffffffe
3 80000000 80000000 0 40000000
3 ffffffff 00000002 0 00000001
3 80000000 00000003 0 00000001
3 00000005 00000007 0 00000000
# Not a multiply, result zero
0 12345678 9abcdef0 0 00000000
0 ffffffff ffffffff 0 00000000
5 00000002 00000003 0 00000000
f 80000000 80000000 0 00000000
# Flush drops the two issues before it and its own
2 fffffffe 00000003 0 ffffffff
1 00000002 00000003 0 00000006
1 00000004 00000005 0 00000014
1 00000006 00000007 1 0000002a
1 00000008 00000009 0 00000048
3 ffffffff 00000010 0 0000000f
# These two are dropped by the next flush
1 00000001 00000001 0 00000001
1 00000009 00000009 0 00000051
2 00000002 00000002 1 00000000
# Issues right after the flush come through
1 00000007 00000007 0 00000031
2 fffffff9 00000007 0 ffffffff
3 00000002 80000000 0 00000001

/* bench/mulUnitTb.sv */
`timescale 1ns/100ps

module mulUnitTb;

    localparam int mulTime     = 3;
    localparam int randomCount = 200;
    localparam int resetCycles = 5;

    // One issued operation and the writeback it should produce.
    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic        flush;
        logic [31:0] result;
        logic        isMul;
        logic [5:0]  pd;
        logic        ready;
        logic        regWr;
        logic [5:0]  tag;
        logic [1:0]  test;
    } vectorT;

    logic          clk;
    logic          reset;
    logic          flush;
    logic [31:0]   busA;
    logic [31:0]   busB;
    mulPkg::mulOpE conf;
    logic [5:0]    pd;
    logic          ready;
    logic          regWr;
    logic [5:0]    tagRob;
    logic [31:0]   resultMul;
    logic [5:0]    pdMul;
    logic          readyMul;
    logic          regWrMul;
    logic [5:0]    tagRobMul;
    logic          isMul;

    vectorT      directed [$];
    vectorT      pending [$];   // Operations in flight, oldest first.
    string       testNames [3] = '{"reset", "directed", "random"};
    int          checkCount [3];
    int          errorCount [3];
    int          otherErrors;
    int          currentTest;
    int          cycleCount;
    int          cycleLimit;
    logic [31:0] rngState;

    mulUnit #(
        .mulTime(mulTime)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .busA     (busA),
        .busB     (busB),
        .conf     (conf),
        .pd       (pd),
        .ready    (ready),
        .regWr    (regWr),
        .tagRob   (tagRob),
        .resultMul(resultMul),
        .pdMul    (pdMul),
        .readyMul (readyMul),
        .regWrMul (regWrMul),
        .tagRobMul(tagRobMul),
        .isMul    (isMul)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Corner values show up often, the rest is plain random.
    function automatic logic [31:0] pickOperand();
        logic [31:0] r;
        r = nextRandom();
        case (r[2:0])
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h7fff_ffff;
            default: return nextRandom();
        endcase
    endfunction

    // Reference result from full 64-bit products.
    function automatic logic [31:0] refResult(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        logic signed [63:0] sProd;
        logic [63:0]        uProd;
        logic [31:0]        r;
        sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uProd = {32'b0, a} * {32'b0, b};
        case (op)
            4'd1:    r = sProd[31:0];
            4'd2:    r = sProd[63:32];
            4'd3:    r = uProd[63:32];
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    task automatic checkValue(input int testIdx, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount[testIdx]++;
        if (actual !== expected) begin
            $display("Error in %s, %s: expected %h, actual %h",
                     testNames[testIdx], field, expected, actual);
            errorCount[testIdx]++;
        end
    endtask

    task automatic reportTest(input int testIdx);
        $display("%s: %0d checks, %0d errors",
                 testNames[testIdx], checkCount[testIdx], errorCount[testIdx]);
    endtask

    task automatic checkRecord(input vectorT e);
        if (int'(e.test) != currentTest) begin
            reportTest(currentTest);
            currentTest = int'(e.test);
        end
        checkValue(currentTest, "resultMul", e.result, resultMul);
        checkValue(currentTest, "isMul", 32'(e.isMul), 32'(isMul));
        checkValue(currentTest, "pdMul", 32'(e.pd), 32'(pdMul));
        checkValue(currentTest, "readyMul", 32'(e.ready), 32'(readyMul));
        checkValue(currentTest, "regWrMul", 32'(e.regWr), 32'(regWrMul));
        checkValue(currentTest, "tagRobMul", 32'(e.tag), 32'(tagRobMul));
    endtask

    // Outputs are stable at the falling edge, so check first, then drive.
    task automatic applyVector(input vectorT v);
        vectorT e;
        vectorT slot;
        @(negedge clk);
        if (pending.size() == mulTime) begin
            checkRecord(pending.pop_front());
        end
        conf   = mulPkg::mulOpE'(v.op);
        busA   = v.a;
        busB   = v.b;
        flush  = v.flush;
        pd     = v.pd;
        ready  = v.ready;
        regWr  = v.regWr;
        tagRob = v.tag;
        e = v;
        e.isMul = (v.op == 4'd1) || (v.op == 4'd2) || (v.op == 4'd3);
        pending.push_back(e);
        if (v.flush) begin
            // Every stage empties, the operation issued with the flush too.
            for (int i = 0; i < pending.size(); i++) begin
                slot = pending[i];
                slot.result = 32'd0;
                slot.isMul  = 1'b0;
                slot.pd     = 6'd0;
                slot.ready  = 1'b0;
                slot.regWr  = 1'b0;
                slot.tag    = 6'd0;
                pending[i] = slot;
            end
        end
    endtask

    task automatic readVectors();
        int          fd;
        int          status;
        int          fields;
        int          idx;
        string       line;
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic        fl;
        logic [31:0] expected;
        vectorT      v;
        idx = 0;
        fd = $fopen("bench/mulInput.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/mulInput.txt, no directed vectors were run");
            otherErrors++;
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                if (status > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h", op, a, b, fl, expected);
                    if (fields == 5) begin
                        v = '0;
                        v.op     = op;
                        v.a      = a;
                        v.b      = b;
                        v.flush  = fl;
                        v.result = expected;
                        v.pd     = 6'(idx) ^ 6'h3f;
                        v.tag    = 6'(idx);   // New tag every cycle.
                        v.ready  = (idx % 4) != 3;
                        v.regWr  = idx[0];
                        v.test   = 2'd1;
                        directed.push_back(v);
                        idx++;
                    end else if (fields > 0) begin
                        $display("Malformed line in bench/mulInput.txt: %s", line);
                        otherErrors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        vectorT      v;
        vectorT      idle;
        logic [31:0] r;
        int          totalChecks;
        int          totalErrors;
        int          assertFails;
        reset  = 1'b1;
        flush  = 1'b0;
        busA   = '0;
        busB   = '0;
        conf   = mulPkg::opOther;
        pd     = '0;
        ready  = 1'b0;
        regWr  = 1'b0;
        tagRob = '0;
        rngState    = 32'd58582;
        currentTest = 1;
        otherErrors = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        for (int i = 0; i < 3; i++) begin
            checkCount[i] = 0;
            errorCount[i] = 0;
        end
        readVectors();
        cycleLimit = directed.size() + randomCount + mulTime + 50;

        repeat (resetCycles) begin
            @(negedge clk);
            checkValue(0, "readyMul", 32'd0, 32'(readyMul));
            checkValue(0, "regWrMul", 32'd0, 32'(regWrMul));
            checkValue(0, "isMul", 32'd0, 32'(isMul));
            checkValue(0, "resultMul", 32'd0, resultMul);
        end
        reset = 1'b0;
        reportTest(0);

        foreach (directed[i]) begin
            applyVector(directed[i]);
        end

        for (int i = 0; i < randomCount; i++) begin
            r = nextRandom();
            v = '0;
            v.op     = {2'b00, r[1:0]};
            v.a      = pickOperand();
            v.b      = pickOperand();
            v.flush  = (r[9:5] == 5'd0);   // Roughly one in 32.
            v.ready  = r[10];
            v.regWr  = r[11];
            v.pd     = r[17:12];
            v.tag    = r[23:18];
            v.result = refResult(v.op, v.a, v.b);
            v.test   = 2'd2;
            applyVector(v);
        end

        idle = '0;
        idle.test = 2'd2;
        repeat (mulTime) begin
            applyVector(idle);   // Pushes the last results out.
        end
        reportTest(currentTest);

        assertFails = UUT.wrapper.sidebandChecks.failCount;
        if (assertFails != 0) begin
            $display("Sideband assertions failed %0d times", assertFails);
        end

        totalChecks = 0;
        totalErrors = otherErrors + assertFails;
        for (int i = 0; i < 3; i++) begin
            totalChecks += checkCount[i];
            totalErrors += errorCount[i];
        end
        $display("Total: %0d checks, %0d errors", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/mulUnit_assertions.sv */
`timescale 1ns/100ps

module mulUnit_assertions #(
    parameter int mulTime = 3
) (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic readyIn,
    input logic readyOut
);

    logic [3:0] quietCount;   // Edges since the last reset or flush.
    int         failCount = 0;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            quietCount <= '0;
        end else if (quietCount < 4'(mulTime)) begin
            quietCount <= quietCount + 4'd1;
        end
    end

    resetClears: assert property (@(posedge clk) reset |=> !readyOut)
        else begin
            failCount++;
            $error("readyMul high after a reset edge");
        end

    flushClears: assert property (@(posedge clk) flush |=> !readyOut)
        else begin
            failCount++;
            $error("readyMul high one cycle after a flush");
        end

    // Ready travels unchanged through a full pipe.
    readyLatency: assert property (@(posedge clk) disable iff (reset)
        quietCount == 4'(mulTime) |-> readyOut == $past(readyIn, mulTime))
        else begin
            failCount++;
            $error("readyMul does not match ready from mulTime cycles before");
        end

endmodule

bind mulWrapper mulUnit_assertions #(
    .mulTime(mulTime)
) sidebandChecks (
    .clk     (clk),
    .reset   (reset),
    .flush   (flush),
    .readyIn (issueTag.ready),
    .readyOut(wbTag.ready)
);

/* rtl/mulArray.sv */
`timescale 1ns/100ps

module mulArray #(
    parameter int mulTime = 3
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [63:0] p
);

    logic [31:0] ppLl;
    logic [31:0] ppLh;
    logic [31:0] ppHl;
    logic [31:0] ppHh;

    // Adds the four partial products at their weights.
    function automatic logic [63:0] combine(
        logic [31:0] ll,
        logic [31:0] lh,
        logic [31:0] hl,
        logic [31:0] hh
    );
        logic [63:0] sum;
        sum = {hh, ll} + {16'b0, lh, 16'b0} + {16'b0, hl, 16'b0};
        return sum;
    endfunction

    assign ppLl = a[15:0] * b[15:0];
    assign ppLh = a[15:0] * b[31:16];
    assign ppHl = a[31:16] * b[15:0];
    assign ppHh = a[31:16] * b[31:16];

    generate
        if (mulTime == 1) begin : gSingle
            logic [63:0] sumComb;
            logic [63:0] sumReg;

            assign sumComb = combine(ppLl, ppLh, ppHl, ppHh);

            always_ff @(posedge clk) begin
                if (reset || clear) begin
                    sumReg <= '0;
                end else begin
                    sumReg <= sumComb;
                end
            end

            assign p = sumReg;
        end else begin : gMulti
            logic [31:0] ppReg [4];
            logic [63:0] sumPipe [2:mulTime];

            always_ff @(posedge clk) begin
                if (reset || clear) begin
                    for (int i = 0; i < 4; i++) begin
                        ppReg[i] <= '0;
                    end
                    for (int i = 2; i <= mulTime; i++) begin
                        sumPipe[i] <= '0;
                    end
                end else begin
                    ppReg[0] <= ppLl;   // Stage one holds the partials.
                    ppReg[1] <= ppLh;
                    ppReg[2] <= ppHl;
                    ppReg[3] <= ppHh;
                    sumPipe[2] <= combine(ppReg[0], ppReg[1], ppReg[2], ppReg[3]);
                    for (int i = 3; i <= mulTime; i++) begin
                        sumPipe[i] <= sumPipe[i-1];   // Pure delay.
                    end
                end
            end

            assign p = sumPipe[mulTime];
        end
    endgenerate

endmodule

/* rtl/mulPkg.sv */
package mulPkg;

    // Operand and sideband widths.
    localparam int dataWidth = 32;
    localparam int prodWidth = 2 * dataWidth;
    localparam int pregWidth = 6;
    localparam int tagWidth  = 6;

    // Operation code from issue. Any other value is not a multiply.
    typedef enum logic [3:0] {
        opOther = 4'h0,
        opMul   = 4'h1,
        opMulh  = 4'h2,
        opMulhu = 4'h3
    } mulOpE;

    // True for the three multiply codes.
    function automatic logic isMulOp(mulOpE op);
        logic hit;
        hit = (op == opMul) || (op == opMulh) || (op == opMulhu);
        return hit;
    endfunction

    // Operands are treated as two's complement only for these.
    function automatic logic isSignedOp(mulOpE op);
        logic hit;
        hit = (op == opMul) || (op == opMulh);
        return hit;
    endfunction

endpackage

/* rtl/mulTagIf.sv */
`timescale 1ns/100ps

// Destination sideband that travels with a multiply.
interface mulTagIf;

    logic [mulPkg::pregWidth-1:0] pd;
    logic                         ready;
    logic                         regWr;
    logic [mulPkg::tagWidth-1:0]  tagRob;

    modport src (
        output pd,
        output ready,
        output regWr,
        output tagRob
    );

    modport dst (
        input  pd,
        input  ready,
        input  regWr,
        input  tagRob
    );

endinterface

/* rtl/mulUnit.sv */
`timescale 1ns/100ps

module mulUnit #(
    parameter int mulTime = 3
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic [mulPkg::dataWidth-1:0] busA,
    input  logic [mulPkg::dataWidth-1:0] busB,
    input  mulPkg::mulOpE                conf,
    input  logic [mulPkg::pregWidth-1:0] pd,
    input  logic                         ready,
    input  logic                         regWr,
    input  logic [mulPkg::tagWidth-1:0]  tagRob,
    output logic [mulPkg::dataWidth-1:0] resultMul,
    output logic [mulPkg::pregWidth-1:0] pdMul,
    output logic                         readyMul,
    output logic                         regWrMul,
    output logic [mulPkg::tagWidth-1:0]  tagRobMul,
    output logic                         isMul
);

    mulTagIf issueTag ();
    mulTagIf wbTag ();

    // Issue side sideband.
    assign issueTag.pd     = pd;
    assign issueTag.ready  = ready;
    assign issueTag.regWr  = regWr;
    assign issueTag.tagRob = tagRob;

    mulWrapper #(
        .mulTime(mulTime)
    ) wrapper (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .busA    (busA),
        .busB    (busB),
        .conf    (conf),
        .issueTag(issueTag.dst),
        .result  (resultMul),
        .wbTag   (wbTag.src),
        .isMul   (isMul)
    );

    assign pdMul     = wbTag.pd;        // Writeback side.
    assign readyMul  = wbTag.ready;
    assign regWrMul  = wbTag.regWr;
    assign tagRobMul = wbTag.tagRob;

endmodule

/* rtl/mulWrapper.sv */
`timescale 1ns/100ps

module mulWrapper #(
    parameter int mulTime = 3
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic [mulPkg::dataWidth-1:0] busA,
    input  logic [mulPkg::dataWidth-1:0] busB,
    input  mulPkg::mulOpE                conf,
    mulTagIf.dst                         issueTag,
    output logic [mulPkg::dataWidth-1:0] result,
    mulTagIf.src                         wbTag,
    output logic                         isMul
);

    localparam int dw = mulPkg::dataWidth;
    localparam int pw = mulPkg::prodWidth;

    typedef struct packed {
        logic [mulPkg::pregWidth-1:0] pd;
        logic                         ready;
        logic                         regWr;
        logic [mulPkg::tagWidth-1:0]  tagRob;
        mulPkg::mulOpE                conf;
        logic                         sign;
    } pipeEntryT;

    // A cleared slot looks like a non-multiply with no destination.
    localparam pipeEntryT idleEntry = '{
        pd:     '0,
        ready:  1'b0,
        regWr:  1'b0,
        tagRob: '0,
        conf:   mulPkg::opOther,
        sign:   1'b0
    };

    logic          signedOp;
    logic          sign;
    logic [dw-1:0] absA;
    logic [dw-1:0] absB;
    logic [pw-1:0] prodAbs;
    logic [pw-1:0] prodSigned;
    pipeEntryT     pipe [mulTime];
    pipeEntryT     last;

    // Sign handling only for MUL and MULH.
    assign signedOp = mulPkg::isSignedOp(conf);
    assign absA = (signedOp && busA[dw-1]) ? (~busA + 1'b1) : busA;
    assign absB = (signedOp && busB[dw-1]) ? (~busB + 1'b1) : busB;
    assign sign = signedOp && (busA[dw-1] ^ busB[dw-1]);

    mulArray #(
        .mulTime(mulTime)
    ) array (
        .clk  (clk),
        .reset(reset),
        .clear(flush),
        .a    (absA),
        .b    (absB),
        .p    (prodAbs)
    );

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < mulTime; i++) begin
                pipe[i] <= idleEntry;
            end
        end else begin
            pipe[0] <= '{
                pd:     issueTag.pd,
                ready:  issueTag.ready,
                regWr:  issueTag.regWr,
                tagRob: issueTag.tagRob,
                conf:   conf,
                sign:   sign
            };
            for (int i = 1; i < mulTime; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign last = pipe[mulTime-1];   // Lines up with the array output.

    assign prodSigned = last.sign ? (~prodAbs + 1'b1) : prodAbs;

    always_comb begin
        case (last.conf)
            mulPkg::opMul:   result = prodSigned[dw-1:0];
            mulPkg::opMulh:  result = prodSigned[pw-1:dw];
            mulPkg::opMulhu: result = prodAbs[pw-1:dw];
            default:         result = '0;
        endcase
    end

    assign isMul = mulPkg::isMulOp(last.conf);

    assign wbTag.pd     = last.pd;
    assign wbTag.ready  = last.ready;
    assign wbTag.regWr  = last.regWr;
    assign wbTag.tagRob = last.tagRob;

endmodule

/* run.sh */
#!/bin/sh
# Builds the multiply unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

buildLog=build.log
simLog=sim.log

verilator --binary --assert -Wno-fatal \
    --top-module mulUnitTb \
    --Mdir obj_dir -o mulUnitSim \
    -f src.f > "$buildLog" 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see $buildLog"
    exit 1
fi

./obj_dir/mulUnitSim > "$simLog" 2>&1
simStatus=$?
cat "$simLog"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TESTS PASSED" "$simLog"; then
    exit 0
fi
echo "Pass message not found in $simLog"
exit 1

/* src.f */
rtl/mulPkg.sv
rtl/mulTagIf.sv
rtl/mulArray.sv
rtl/mulWrapper.sv
rtl/mulUnit.sv
bench/mulUnit_assertions.sv
bench/mulUnitTb.sv
